//--- mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int XLEN       = 32;                 // Data word width
	localparam int REG_AW     = 5;                  // Register address width
	localparam int PC_W       = 16;                 // Word PC width, instruction port index
	localparam int IMM_W      = 16;                 // I-type immediate field
	localparam int TARGET_W   = 26;                 // J-type target field
	localparam int DMEM_WORDS = 256;                // Data memory depth in words
	localparam int DMEM_AW    = $clog2(DMEM_WORDS); // Word index bits above the byte lane

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE  = 6'b000000, // Decoded further by funct
		OP_REGIMM = 6'b000001, // Decoded further by rt
		OP_J      = 6'b000010,
		OP_JAL    = 6'b000011,
		OP_BEQ    = 6'b000100,
		OP_BNE    = 6'b000101,
		OP_ADDI   = 6'b001000,
		OP_ADDIU  = 6'b001001,
		OP_SLTI   = 6'b001010,
		OP_ANDI   = 6'b001100,
		OP_ORI    = 6'b001101,
		OP_XORI   = 6'b001110,
		OP_LUI    = 6'b001111,
		OP_LB     = 6'b100000,
		OP_LW     = 6'b100011,
		OP_SB     = 6'b101000,
		OP_SW     = 6'b101011
	} opcode_e;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		F_JR   = 6'b001000,
		F_JALR = 6'b001001,
		F_ADDU = 6'b100001,
		F_SUBU = 6'b100011,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_XOR  = 6'b100110,
		F_SLT  = 6'b101010
	} funct_e;

	localparam logic [REG_AW-1:0] RT_BGEZ   = 5'b00001; // REGIMM rt selectors
	localparam logic [REG_AW-1:0] RT_BGEZAL = 5'b10001;
	localparam logic [REG_AW-1:0] RA_REG    = 5'd31;    // Link register $ra

endpackage

//--- mips_ctrl_pkg.sv
package mips_ctrl_pkg;

	// Next PC source
	typedef enum logic [1:0] {
		PC_BRANCH = 2'b00, // PC+1+offset when the condition holds
		PC_JUMP   = 2'b01, // Low bits of target26
		PC_REG    = 2'b10, // Value of rs, JR and JALR
		PC_NEXT   = 2'b11  // Plain PC+1
	} pc_src_e;

	// Destination register select
	typedef enum logic [1:0] {
		DST_RT = 2'd0, // I-type and loads
		DST_RD = 2'd1, // R-type and JALR
		DST_RA = 2'd2  // JAL and BGEZAL link to $ra
	} reg_dst_e;

	// Write-back data select
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1, // Load data from data memory
		WB_LINK = 2'd2  // Return address PC+1
	} wb_src_e;

	// ALU operation as issued by the decoder
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_FUNCT = 4'd6,  // ALU resolves funct on its own
		ALU_GEZ   = 4'd7,  // 1 when a >= 0 signed
		ALU_LUI   = 4'd9,
		ALU_SLT   = 4'd10
	} alu_op_e;

	// Branch taken on ALU zero flag set or clear
	typedef enum logic {
		BR_NE = 1'b0,
		BR_EQ = 1'b1
	} br_cond_e;

endpackage

//--- core_ifs.sv
`timescale 1ns/100ps

// Decoded control fields from control_unit to the datapath
interface ctrl_if import mips_ctrl_pkg::*; ();
	pc_src_e  pc_src;
	reg_dst_e reg_dst;
	wb_src_e  wb_src;
	alu_op_e  alu_op;
	logic     alu_imm;    // ALU operand b is the extended immediate
	logic     reg_we;     // Register write, single bit
	logic     mem_we;     // Data memory store
	logic     mem_byte;   // Byte access instead of word
	logic     imm_signed; // Sign or zero extension of imm16
	br_cond_e br_cond;

	modport decoder (output pc_src, reg_dst, wb_src, alu_op, alu_imm, reg_we, mem_we,
		mem_byte, imm_signed, br_cond);
	modport datapath (input pc_src, reg_dst, wb_src, alu_op, alu_imm, reg_we, mem_we,
		mem_byte, imm_signed, br_cond);
endinterface

// Data memory access, completes within the cycle
interface dmem_if import mips_isa_pkg::*; ();
	logic [XLEN-1:0] addr;      // Byte address
	logic [XLEN-1:0] wdata;
	logic            we;
	logic            byte_mode; // Lane chosen by addr[1:0]
	logic [XLEN-1:0] rdata;     // Combinational read

	modport master (output addr, wdata, we, byte_mode, input rdata);
	modport slave (input addr, wdata, we, byte_mode, output rdata);
endinterface

//--- control_unit.sv
`timescale 1ns/100ps

module control_unit import mips_isa_pkg::*, mips_ctrl_pkg::*; (
	input  opcode_e           opcode, // instr[31:26]
	input  funct_e            funct,  // instr[5:0], R-type only
	input  logic [REG_AW-1:0] rt,     // Selects BGEZ or BGEZAL
	ctrl_if.decoder           ctrl
);

	always_comb
	begin
		ctrl.pc_src     = PC_NEXT; // Defaults give a no-op
		ctrl.reg_dst    = DST_RT;
		ctrl.wb_src     = WB_ALU;
		ctrl.alu_op     = ALU_ADD;
		ctrl.alu_imm    = 1'b0;
		ctrl.reg_we     = 1'b0;
		ctrl.mem_we     = 1'b0;
		ctrl.mem_byte   = 1'b0;
		ctrl.imm_signed = 1'b1;
		ctrl.br_cond    = BR_EQ;

		case (opcode)
			OP_RTYPE:
			begin
				ctrl.reg_dst = DST_RD; // Three register format
				case (funct)
					F_JR:
						ctrl.pc_src = PC_REG; // PC = rs
					F_JALR:
					begin
						ctrl.pc_src = PC_REG;
						ctrl.wb_src = WB_LINK; // rd gets PC+1
						ctrl.reg_we = 1'b1;
					end
					F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT:
					begin
						ctrl.alu_op = ALU_FUNCT; // ALU decodes funct itself
						ctrl.reg_we = 1'b1;
					end
					default: ; // Unsupported funct, no-op
				endcase
			end
			OP_REGIMM:
			begin
				ctrl.alu_op  = ALU_GEZ; // Result nonzero when rs >= 0
				ctrl.br_cond = BR_NE;   // So taken on zero flag clear
				case (rt)
					RT_BGEZ:
						ctrl.pc_src = PC_BRANCH;
					RT_BGEZAL:
					begin
						ctrl.pc_src  = PC_BRANCH;
						ctrl.reg_dst = DST_RA;  // Links taken or not
						ctrl.wb_src  = WB_LINK;
						ctrl.reg_we  = 1'b1;
					end
					default: ;
				endcase
			end
			OP_J:
				ctrl.pc_src = PC_JUMP;
			OP_JAL:
			begin
				ctrl.pc_src  = PC_JUMP;
				ctrl.reg_dst = DST_RA;
				ctrl.wb_src  = WB_LINK;
				ctrl.reg_we  = 1'b1;
			end
			OP_BEQ, OP_BNE:
			begin
				ctrl.pc_src  = PC_BRANCH;
				ctrl.alu_op  = ALU_SUB;  // rs - rt, zero on equal
				ctrl.br_cond = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			begin
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
				case (opcode)
					OP_SLTI: ctrl.alu_op = ALU_SLT;
					OP_ANDI: ctrl.alu_op = ALU_AND;
					OP_ORI:  ctrl.alu_op = ALU_OR;
					OP_XORI: ctrl.alu_op = ALU_XOR;
					OP_LUI:  ctrl.alu_op = ALU_LUI;
					default: ctrl.alu_op = ALU_ADD; // ADDI and ADDIU
				endcase
				// Logic ops and LUI take a zero-extended immediate
				ctrl.imm_signed = (opcode == OP_ADDI) || (opcode == OP_ADDIU) ||
					(opcode == OP_SLTI);
			end
			OP_LB, OP_LW:
			begin
				ctrl.alu_imm  = 1'b1; // Address = rs + offset
				ctrl.wb_src   = WB_MEM;
				ctrl.reg_we   = 1'b1;
				ctrl.mem_byte = (opcode == OP_LB);
			end
			OP_SB, OP_SW:
			begin
				ctrl.alu_imm  = 1'b1;
				ctrl.mem_we   = 1'b1; // Store data is rt
				ctrl.mem_byte = (opcode == OP_SB);
			end
			default: ; // Unknown opcode, PC+1 only
		endcase
	end

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu import mips_isa_pkg::*, mips_ctrl_pkg::*; (
	input  logic [XLEN-1:0] a,      // rs
	input  logic [XLEN-1:0] b,      // rt or extended immediate
	input  alu_op_e         op,
	input  funct_e          funct,  // Used only with ALU_FUNCT
	output logic [XLEN-1:0] result,
	output logic            zero    // Branch decision flag
);

	alu_op_e eff_op; // Operation after funct resolution

	always_comb
	begin
		eff_op = op;
		if (op == ALU_FUNCT)
		begin
			case (funct)
				F_ADDU:  eff_op = ALU_ADD;
				F_SUBU:  eff_op = ALU_SUB;
				F_AND:   eff_op = ALU_AND;
				F_OR:    eff_op = ALU_OR;
				F_XOR:   eff_op = ALU_XOR;
				F_SLT:   eff_op = ALU_SLT;
				default: eff_op = ALU_ADD; // Not issued by the decoder
			endcase
		end
	end

	always_comb
	begin
		case (eff_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_LUI: result = {b[XLEN/2-1:0], {(XLEN/2){1'b0}}}; // imm16 to upper half
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_GEZ: result = {{(XLEN-1){1'b0}}, ~a[XLEN-1]}; // Sign bit clear
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file import mips_isa_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [REG_AW-1:0] ra1,  // Read port 1, rs
	input  logic [REG_AW-1:0] ra2,  // Read port 2, rt
	output logic [XLEN-1:0]   rd1,
	output logic [XLEN-1:0]   rd2,
	input  logic              we,
	input  logic [REG_AW-1:0] wa,
	input  logic [XLEN-1:0]   wd
);

	logic [XLEN-1:0] regs [2**REG_AW];

	// Register 0 clears on reset and is never written, so it reads as zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 2**REG_AW; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we && (wa != '0))
		begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = regs[ra1]; // Asynchronous reads
	assign rd2 = regs[ra2];

endmodule

//--- data_mem.sv
`timescale 1ns/100ps

module data_mem import mips_isa_pkg::*; (
	input  logic  clk,
	dmem_if.slave bus
);

	logic [XLEN-1:0]    mem [DMEM_WORDS];
	logic [DMEM_AW-1:0] word_idx;  // Byte address bits [9:2]
	logic [1:0]         lane;      // Little-endian byte lane
	logic [XLEN-1:0]    word_rd;
	logic [7:0]         byte_rd;

	assign word_idx = bus.addr[DMEM_AW+1:2];
	assign lane     = bus.addr[1:0];
	assign word_rd  = mem[word_idx];
	assign byte_rd  = word_rd[lane*8 +: 8];

	// LB sign-extends the selected lane
	assign bus.rdata = bus.byte_mode ? {{(XLEN-8){byte_rd[7]}}, byte_rd} : word_rd;

	always_ff @(posedge clk)
	begin
		if (bus.we)
		begin
			if (bus.byte_mode)
			begin
				mem[word_idx][lane*8 +: 8] <= bus.wdata[7:0]; // SB, one lane only
			end
			else
			begin
				mem[word_idx] <= bus.wdata;
			end
		end
	end

endmodule

//--- mips_core.sv
`timescale 1ns/100ps

module mips_core import mips_isa_pkg::*, mips_ctrl_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [XLEN-1:0]   imem_data,  // Instruction at imem_addr, same cycle
	output logic [PC_W-1:0]   imem_addr,
	output logic              wb_en,      // Register write this cycle
	output logic [REG_AW-1:0] wb_reg,
	output logic [XLEN-1:0]   wb_data,
	output logic              mem_we,     // Store this cycle
	output logic [XLEN-1:0]   mem_addr,
	output logic [XLEN-1:0]   mem_wdata
);

	logic [PC_W-1:0]     pc;
	logic [PC_W-1:0]     pc_plus1;
	logic [PC_W-1:0]     pc_next;
	opcode_e             opcode;
	funct_e              funct;
	logic [REG_AW-1:0]   rs;
	logic [REG_AW-1:0]   rt;
	logic [REG_AW-1:0]   rd;
	logic [IMM_W-1:0]    imm16;
	logic [TARGET_W-1:0] target26;
	logic [XLEN-1:0]     imm_sext;
	logic [XLEN-1:0]     imm_ext;
	logic [XLEN-1:0]     rd1;
	logic [XLEN-1:0]     rd2;
	logic [XLEN-1:0]     alu_b;
	logic [XLEN-1:0]     alu_result;
	logic                alu_zero;
	logic                br_taken;

	ctrl_if ctrl_bus ();
	dmem_if dmem_bus ();

	// Instruction fields
	assign opcode   = opcode_e'(imem_data[31:26]);
	assign rs       = imem_data[25:21];
	assign rt       = imem_data[20:16];
	assign rd       = imem_data[15:11];
	assign funct    = funct_e'(imem_data[5:0]);
	assign imm16    = imem_data[IMM_W-1:0];
	assign target26 = imem_data[TARGET_W-1:0];

	assign imm_sext = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
	assign imm_ext  = ctrl_bus.imm_signed ? imm_sext : {{(XLEN-IMM_W){1'b0}}, imm16};
	assign alu_b    = ctrl_bus.alu_imm ? imm_ext : rd2;

	control_unit u_ctrl (.opcode(opcode), .funct(funct), .rt(rt), .ctrl(ctrl_bus.decoder));

	reg_file u_rf (.clk(clk), .rst_n(rst_n), .ra1(rs), .ra2(rt), .rd1(rd1), .rd2(rd2),
		.we(wb_en), .wa(wb_reg), .wd(wb_data));

	alu u_alu (.a(rd1), .b(alu_b), .op(ctrl_bus.alu_op), .funct(funct),
		.result(alu_result), .zero(alu_zero));

	data_mem u_dmem (.clk(clk), .bus(dmem_bus.slave));

	// BEQ on zero set, BNE and BGEZ on zero clear
	assign br_taken = (ctrl_bus.br_cond == BR_EQ) ? alu_zero : ~alu_zero;
	assign pc_plus1 = pc + 1'b1;

	always_comb
	begin
		case (ctrl_bus.pc_src)
			PC_BRANCH: pc_next = br_taken ? (pc_plus1 + imm_sext[PC_W-1:0]) : pc_plus1;
			PC_JUMP:   pc_next = target26[PC_W-1:0];
			PC_REG:    pc_next = rd1[PC_W-1:0]; // JR and JALR
			default:   pc_next = pc_plus1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc <= '0;
		else
			pc <= pc_next;
	end

	always_comb
	begin
		case (ctrl_bus.reg_dst)
			DST_RD:  wb_reg = rd;
			DST_RA:  wb_reg = RA_REG;
			default: wb_reg = rt;
		endcase
		case (ctrl_bus.wb_src)
			WB_MEM:  wb_data = dmem_bus.rdata;
			WB_LINK: wb_data = {{(XLEN-PC_W){1'b0}}, pc_plus1}; // Return address
			default: wb_data = alu_result;
		endcase
	end

	// Writes held off in reset, register 0 writes dropped here
	assign wb_en  = rst_n & ctrl_bus.reg_we & (wb_reg != '0);
	assign mem_we = rst_n & ctrl_bus.mem_we;

	assign dmem_bus.addr      = alu_result; // rs + offset
	assign dmem_bus.wdata     = rd2;
	assign dmem_bus.we        = mem_we;
	assign dmem_bus.byte_mode = ctrl_bus.mem_byte;

	assign imem_addr = pc;
	assign mem_addr  = alu_result;
	assign mem_wdata = rd2;

endmodule

//--- mips_core_asserts.sv
`timescale 1ns/100ps

module mips_core_asserts import mips_isa_pkg::*; (
	input logic              clk,
	input logic              rst_n,
	input logic              wb_en,
	input logic [REG_AW-1:0] wb_reg,
	input logic              mem_we
);

	int unsigned failures = 0; // Read by the testbench at the end

	// No architectural write while reset is held
	assert property (@(posedge clk) !rst_n |-> (!wb_en && !mem_we))
		else
		begin
			failures++;
			$error("Write enable high during reset");
		end

	assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> (wb_reg != '0))
		else
		begin
			failures++;
			$error("Register write aimed at register 0");
		end

	assert property (@(posedge clk) disable iff (!rst_n) !(wb_en && mem_we))
		else
		begin
			failures++;
			$error("Store and register write in the same cycle");
		end

endmodule

bind mips_core mips_core_asserts u_asserts (.clk(clk), .rst_n(rst_n), .wb_en(wb_en),
	.wb_reg(wb_reg), .mem_we(mem_we));

//--- tb_mips_core.sv
`timescale 1ns/100ps

module tb_mips_core import mips_isa_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int PROG_WORDS = 256; // Program space seen by the testbench

	typedef struct packed {
		logic [PC_W-1:0]   pc;
		logic [XLEN-1:0]   instr;
		logic              wb_en;
		logic [REG_AW-1:0] wb_reg;
		logic [XLEN-1:0]   wb_data;
		logic              mem_we;
		logic [XLEN-1:0]   mem_addr;
		logic [XLEN-1:0]   mem_wdata;
	} step_t;

	logic              clk;
	logic              rst_n;
	logic [XLEN-1:0]   imem_data;
	logic [PC_W-1:0]   imem_addr;
	logic              wb_en;
	logic [REG_AW-1:0] wb_reg;
	logic [XLEN-1:0]   wb_data;
	logic              mem_we;
	logic [XLEN-1:0]   mem_addr;
	logic [XLEN-1:0]   mem_wdata;

	logic [XLEN-1:0] prog [PROG_WORDS]; // Instruction port contents
	step_t           steps [$];         // Expected PC trace and writes
	bit              table_ready = 1'b0;

	mips_core u_dut (.clk(clk), .rst_n(rst_n), .imem_data(imem_data), .imem_addr(imem_addr),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata));

	function automatic logic [XLEN-1:0] r_type(funct_e f, int rs, int rt, int rd);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
	endfunction

	function automatic logic [XLEN-1:0] i_type(opcode_e op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [XLEN-1:0] regimm(logic [4:0] sel, int rs, logic [15:0] imm);
		return {OP_REGIMM, 5'(rs), sel, imm}; // rt field picks the branch
	endfunction

	function automatic logic [XLEN-1:0] j_type(opcode_e op, logic [25:0] target);
		return {op, target};
	endfunction

	task automatic add_step(int pc, logic [XLEN-1:0] instr, bit wen, int wreg,
		logic [XLEN-1:0] wdata, bit mwe, logic [XLEN-1:0] maddr, logic [XLEN-1:0] mwdata);
		steps.push_back({PC_W'(pc), instr, wen, 5'(wreg), wdata, mwe, maddr, mwdata});
	endtask

	task automatic report_mismatch(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] got);
		$display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, got);
		$display("Simulation failed");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic check_step(int idx);
		step_t s;
		s = steps[idx];
		assert (imem_addr == s.pc) else report_mismatch("imem_addr", 32'(s.pc), 32'(imem_addr));
		assert (wb_en == s.wb_en) else report_mismatch("wb_en", 32'(s.wb_en), 32'(wb_en));
		assert (mem_we == s.mem_we) else report_mismatch("mem_we", 32'(s.mem_we), 32'(mem_we));
		if (s.wb_en)
		begin
			assert (wb_reg == s.wb_reg) else report_mismatch("wb_reg", 32'(s.wb_reg), 32'(wb_reg));
			assert (wb_data == s.wb_data) else report_mismatch("wb_data", s.wb_data, wb_data);
		end
		if (s.mem_we)
		begin
			assert (mem_addr == s.mem_addr) else report_mismatch("mem_addr", s.mem_addr, mem_addr);
			assert (mem_wdata == s.mem_wdata)
				else report_mismatch("mem_wdata", s.mem_wdata, mem_wdata);
		end
	endtask

	task automatic build_program();
		for (int a = 0; a < PROG_WORDS; a++)
			prog[a] = {6'h3F, 18'h0, 8'(a)}; // Unused slots hold unknown opcodes
		add_step(0, i_type(OP_ADDI, 0, 1, 16'hFFFB), 1, 1, 32'hFFFF_FFFB, 0, 0, 0); // -5
		add_step(1, i_type(OP_ORI, 0, 2, 16'h8001), 1, 2, 32'h0000_8001, 0, 0, 0);  // Zero ext
		add_step(2, i_type(OP_ANDI, 1, 3, 16'h80F0), 1, 3, 32'h0000_80F0, 0, 0, 0);
		add_step(3, i_type(OP_XORI, 2, 4, 16'hFFFF), 1, 4, 32'h0000_7FFE, 0, 0, 0);
		add_step(4, i_type(OP_LUI, 0, 5, 16'h1234), 1, 5, 32'h1234_0000, 0, 0, 0);
		add_step(5, i_type(OP_SLTI, 1, 6, 16'hFFFF), 1, 6, 1, 0, 0, 0);             // -5 < -1
		add_step(6, i_type(OP_SLTI, 2, 7, 16'hFFFF), 1, 7, 0, 0, 0, 0);             // Positive
		add_step(7, i_type(OP_ADDIU, 5, 8, 16'h5678), 1, 8, 32'h1234_5678, 0, 0, 0);
		add_step(8, r_type(F_ADDU, 1, 2, 9), 1, 9, 32'h0000_7FFC, 0, 0, 0);
		add_step(9, r_type(F_SUBU, 2, 1, 10), 1, 10, 32'h0000_8006, 0, 0, 0);
		add_step(10, r_type(F_AND, 8, 3, 11), 1, 11, 32'h0000_0070, 0, 0, 0);
		add_step(11, r_type(F_OR, 5, 4, 12), 1, 12, 32'h1234_7FFE, 0, 0, 0);
		add_step(12, r_type(F_XOR, 8, 5, 13), 1, 13, 32'h0000_5678, 0, 0, 0);
		add_step(13, r_type(F_SLT, 1, 6, 14), 1, 14, 1, 0, 0, 0);
		add_step(14, r_type(F_ADDU, 1, 2, 0), 0, 0, 0, 0, 0, 0);                    // $zero dest
		add_step(15, r_type(F_ADDU, 0, 4, 15), 1, 15, 32'h0000_7FFE, 0, 0, 0);      // $zero reads 0
		add_step(16, i_type(OP_SW, 0, 8, 16'd8), 0, 0, 0, 1, 8, 32'h1234_5678);
		add_step(17, i_type(OP_SB, 0, 1, 16'd9), 0, 0, 0, 1, 9, 32'hFFFF_FFFB);     // Lane 1
		add_step(18, i_type(OP_LW, 0, 16, 16'd8), 1, 16, 32'h1234_FB78, 0, 0, 0);
		add_step(19, i_type(OP_LB, 0, 17, 16'd9), 1, 17, 32'hFFFF_FFFB, 0, 0, 0);
		add_step(20, i_type(OP_LB, 0, 18, 16'd10), 1, 18, 32'h0000_0034, 0, 0, 0);
		add_step(21, i_type(OP_BEQ, 6, 14, 16'd2), 0, 0, 0, 0, 0, 0);               // Taken
		add_step(24, i_type(OP_BEQ, 6, 7, 16'd5), 0, 0, 0, 0, 0, 0);                // Not taken
		add_step(25, i_type(OP_BNE, 6, 7, 16'd1), 0, 0, 0, 0, 0, 0);
		add_step(27, regimm(RT_BGEZ, 1, 16'd3), 0, 0, 0, 0, 0, 0);                  // rs negative
		add_step(28, regimm(RT_BGEZAL, 2, 16'd2), 1, 31, 29, 0, 0, 0);
		add_step(31, j_type(OP_J, 26'd40), 0, 0, 0, 0, 0, 0);
		add_step(40, j_type(OP_JAL, 26'd50), 1, 31, 41, 0, 0, 0);
		add_step(50, r_type(F_JR, 31, 0, 0), 0, 0, 0, 0, 0, 0);                     // Back to 41
		add_step(41, i_type(OP_ADDIU, 0, 19, 16'd60), 1, 19, 60, 0, 0, 0);
		add_step(42, r_type(F_JALR, 19, 0, 20), 1, 20, 43, 0, 0, 0);
		add_step(60, 32'h5022_0004, 0, 0, 0, 0, 0, 0);                             // Unknown op
		add_step(61, r_type(F_ADDU, 20, 0, 21), 1, 21, 43, 0, 0, 0);
		foreach (steps[i])
			prog[steps[i].pc] = steps[i].instr; // Each row's instruction at its PC
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Instruction port follows the PC shortly after each edge
	initial
	begin
		imem_data = '0;
		forever
		begin
			@(posedge clk);
			#2;
			imem_data = prog[imem_addr[7:0]];
		end
	end

	initial
	begin
		wait (table_ready);
		#((steps.size() + 10) * CLK_PERIOD);
		$display("Timeout: step table not finished after %0d cycles", steps.size() + 10);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end

	// Bound checker failures stop the run at once
	initial
	begin
		wait (u_dut.u_asserts.failures != 0);
		$display("A bound assertion on the core ports failed at %0t ns", $time);
		$display("Simulation failed");
		$fatal(1, "Stopped at first assertion failure");
	end

	initial
	begin
		rst_n = 1'b0;
		build_program();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		foreach (steps[i])
		begin
			@(negedge clk); // Outputs settled mid-cycle
			check_step(i);
		end
		@(negedge clk); // Last row sampled by the bound checker
		if (u_dut.u_asserts.failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- compile.f
mips_isa_pkg.sv
mips_ctrl_pkg.sv
core_ifs.sv
control_unit.sv
alu.sv
reg_file.sv
data_mem.sv
mips_core.sv
mips_core_asserts.sv
tb_mips_core.sv
